// File: Bender.yml
package:
  name: exec_cluster

sources:
  - rtl/isaPkg.sv
  - rtl/pipePkg.sv
  - rtl/controlDecoder.sv
  - rtl/aluCore.sv
  - rtl/execLane.sv
  - rtl/issueDispatcher.sv
  - rtl/resultCollector.sv
  - rtl/execCluster.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/execClusterTb.sv

// File: rtl/aluCore.sv
/* 32-bit ALU. Shifts move b by a[4:0].
   Compare codes return 0 or 1 in bit 0 only. */
`timescale 1ns/1ns
module aluCore (
    input  isaPkg::aluFun_t fun,
    input  logic            sign,
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    output logic [31:0]     y
);
    import isaPkg::*;

    logic lessThan;
    logic aZero;

    assign lessThan = sign ? ($signed(a) < $signed(b)) : (a < b);
    assign aZero    = (a == 32'd0);

    always_comb begin
        y = 32'd0;
        case (fun)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_NOR: y = ~(a | b);
            ALU_SLL: y = b << a[4:0];
            ALU_SRL: y = b >> a[4:0];
            ALU_SRA: y = $signed(b) >>> a[4:0];
            ALU_LT:  y[0] = lessThan;
            ALU_EQ:  y[0] = (a == b);
            ALU_NE:  y[0] = (a != b);
            ALU_LEZ: y[0] = a[31] | aZero;    // signed test against zero
            ALU_GTZ: y[0] = !a[31] && !aZero;
            ALU_LTZ: y[0] = a[31];
            default: y = 32'd0;
        endcase
    end

endmodule

// File: rtl/controlDecoder.sv
/* Main control decoder. irq outranks everything, then an illegal opcode.
   Unknown R-type functs are not trapped and decode as add. */
`timescale 1ns/1ns
module controlDecoder (
    input  isaPkg::instr_t instr,
    input  logic           irq,
    output isaPkg::ctrl_t  ctrl
);
    import isaPkg::*;

    logic [5:0] op;
    logic [5:0] fn;
    logic       illegal;

    assign op = instr.r.opcode;
    assign fn = instr.r.funct;

    always_comb begin
        case (op)
            OP_RTYPE, OP_BLTZ, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_LUI, OP_LW, OP_SW:
                illegal = 1'b0;
            default:
                illegal = 1'b1;
        endcase
    end

    always_comb begin
        ctrl.pcSrc    = PC_SEQ;
        ctrl.regDst   = DST_RT;
        ctrl.memToReg = WB_ALU;
        if (irq) begin
            ctrl.pcSrc    = PC_IRQ;
            ctrl.regDst   = DST_TRAP;
            ctrl.memToReg = WB_PC;    // resume at the interrupted instruction
        end else if (illegal) begin
            ctrl.pcSrc    = PC_EXC;
            ctrl.regDst   = DST_TRAP;
            ctrl.memToReg = WB_LINK;
        end else begin
            case (op)
                OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ: ctrl.pcSrc = PC_BRANCH;
                OP_J, OP_JAL:                              ctrl.pcSrc = PC_JUMP;
                OP_RTYPE: begin
                    if (fn == FN_JR || fn == FN_JALR) begin
                        ctrl.pcSrc = PC_REG;
                    end
                end
                default: ctrl.pcSrc = PC_SEQ;
            endcase
            case (op)
                OP_JAL:   ctrl.regDst = DST_LINK;
                OP_RTYPE: ctrl.regDst = DST_RD;    // also jalr link into rd
                default:  ctrl.regDst = DST_RT;
            endcase
            if (op == OP_LW) begin
                ctrl.memToReg = WB_MEM;
            end else if (op == OP_JAL || (op == OP_RTYPE && fn == FN_JALR)) begin
                ctrl.memToReg = WB_LINK;
            end
        end

        ctrl.sign = !((op == OP_RTYPE && fn == FN_SLTU) || op == OP_SLTIU);

        case (op)
            OP_SW, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_J: ctrl.regWrite = 1'b0;
            OP_RTYPE: ctrl.regWrite = (fn != FN_JR);
            default:  ctrl.regWrite = 1'b1;
        endcase

        ctrl.aluSrc1 = (op == OP_RTYPE) && (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA);
        // beq and bne compare rs with rt
        ctrl.aluSrc2 = !(op == OP_RTYPE || op == OP_BEQ || op == OP_BNE);

        case (op)
            OP_RTYPE: begin
                case (fn)
                    FN_ADD, FN_ADDU: ctrl.aluFun = ALU_ADD;
                    FN_SUB, FN_SUBU: ctrl.aluFun = ALU_SUB;
                    FN_AND:          ctrl.aluFun = ALU_AND;
                    FN_OR:           ctrl.aluFun = ALU_OR;
                    FN_XOR:          ctrl.aluFun = ALU_XOR;
                    FN_NOR:          ctrl.aluFun = ALU_NOR;
                    FN_SLL:          ctrl.aluFun = ALU_SLL;
                    FN_SRL:          ctrl.aluFun = ALU_SRL;
                    FN_SRA:          ctrl.aluFun = ALU_SRA;
                    FN_SLT, FN_SLTU: ctrl.aluFun = ALU_LT;
                    default:         ctrl.aluFun = ALU_ADD;
                endcase
            end
            OP_ANDI:           ctrl.aluFun = ALU_AND;
            OP_SLTI, OP_SLTIU: ctrl.aluFun = ALU_LT;
            OP_BEQ:            ctrl.aluFun = ALU_EQ;
            OP_BNE:            ctrl.aluFun = ALU_NE;
            OP_BLEZ:           ctrl.aluFun = ALU_LEZ;
            OP_BGTZ:           ctrl.aluFun = ALU_GTZ;
            OP_BLTZ:           ctrl.aluFun = ALU_LTZ;
            default:           ctrl.aluFun = ALU_ADD;    // addi, lui, lw, sw address
        endcase

        ctrl.memRead  = (op == OP_LW);
        ctrl.memWrite = (op == OP_SW);
        ctrl.extOp    = (op != OP_ANDI);    // andi zero-extends
        ctrl.luOp     = (op == OP_LUI);
    end

endmodule

// File: rtl/execCluster.sv
/* Execute cluster top. Up to NUM_LANES packets in flight, in-order output.
   Latency is one cycle when the target lane is empty and at the head. */
`timescale 1ns/1ns
module execCluster (
    input  logic             clk,
    input  logic             rst,
    input  logic             inValid,
    output logic             inReady,
    input  pipePkg::issue_t  inPkt,
    output logic             outValid,
    input  logic             outReady,
    output pipePkg::result_t outPkt
);
    import pipePkg::*;

    logic [NUM_LANES-1:0] laneInValid;
    logic [NUM_LANES-1:0] laneInReady;
    logic [NUM_LANES-1:0] laneOutValid;
    logic [NUM_LANES-1:0] laneOutReady;
    issue_t               laneInPkt;
    result_t              laneOutPkt [NUM_LANES];

    issueDispatcher dispatcher (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inReady(inReady), .inPkt(inPkt),
        .laneValid(laneInValid), .laneReady(laneInReady), .lanePkt(laneInPkt)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : genLane
        execLane lane (
            .clk(clk), .rst(rst),
            .inValid(laneInValid[g]), .inReady(laneInReady[g]), .inPkt(laneInPkt),
            .outValid(laneOutValid[g]), .outReady(laneOutReady[g]), .outPkt(laneOutPkt[g])
        );
    end

    resultCollector collector (
        .clk(clk), .rst(rst),
        .laneValid(laneOutValid), .laneReady(laneOutReady), .lanePkt(laneOutPkt),
        .outValid(outValid), .outReady(outReady), .outPkt(outPkt)
    );

endmodule

// File: rtl/execLane.sv
/* One execute lane. The result is computed in the accepting cycle and held in a
   one-entry register. A trapped lw or sw still reports its memory request. */
`timescale 1ns/1ns
module execLane (
    input  logic             clk,
    input  logic             rst,
    input  logic             inValid,
    output logic             inReady,
    input  pipePkg::issue_t  inPkt,
    output logic             outValid,
    input  logic             outReady,
    output pipePkg::result_t outPkt
);
    import isaPkg::*;
    import pipePkg::*;

    ctrl_t       ctrl;
    result_t     res;
    logic [15:0] imm;
    logic [31:0] immExt;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluY;
    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;

    controlDecoder decoder (.instr(inPkt.instr), .irq(inPkt.irq), .ctrl(ctrl));

    assign imm          = inPkt.instr.i.imm16;
    assign immExt       = ctrl.extOp ? {{16{imm[15]}}, imm} : {16'd0, imm};
    assign opA          = ctrl.aluSrc1 ? {27'd0, inPkt.instr.r.shamt} : inPkt.rsVal;
    assign opB          = !ctrl.aluSrc2 ? inPkt.rtVal : (ctrl.luOp ? {imm, 16'd0} : immExt);
    assign pcPlus4      = inPkt.pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};

    aluCore alu (.fun(ctrl.aluFun), .sign(ctrl.sign), .a(opA), .b(opB), .y(aluY));

    always_comb begin
        res.trap      = (ctrl.pcSrc == PC_IRQ) || (ctrl.pcSrc == PC_EXC);
        res.regWrite  = ctrl.regWrite | res.trap;
        res.memRead   = ctrl.memRead;
        res.memWrite  = ctrl.memWrite;
        res.memAddr   = aluY;
        res.storeData = inPkt.rtVal;
        case (ctrl.regDst)
            DST_RT:   res.wbReg = inPkt.instr.i.rt;
            DST_RD:   res.wbReg = inPkt.instr.r.rd;
            DST_LINK: res.wbReg = LINK_REG;
            default:  res.wbReg = TRAP_REG;
        endcase
        case (ctrl.memToReg)
            WB_ALU:  res.wbVal = aluY;
            WB_MEM:  res.wbVal = 32'd0;
            WB_LINK: res.wbVal = pcPlus4;
            default: res.wbVal = inPkt.pc;
        endcase
        case (ctrl.pcSrc)
            PC_BRANCH: res.nextPc = aluY[0] ? branchTarget : pcPlus4;
            PC_JUMP:   res.nextPc = {pcPlus4[31:28], inPkt.instr[25:0], 2'b00};
            PC_REG:    res.nextPc = inPkt.rsVal;
            PC_IRQ:    res.nextPc = IRQ_VECTOR;
            PC_EXC:    res.nextPc = EXC_VECTOR;
            default:   res.nextPc = pcPlus4;
        endcase
    end

    assign inReady = !outValid || outReady;    // empty or draining now

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outPkt <= res;
        end
    end

endmodule

// File: rtl/isaPkg.sv
/* MIPS-I subset encodings and the decoded control word.
   Only the opcodes listed here are legal; every other opcode takes the exception path. */
package isaPkg;

    // opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_BLTZ  = 6'h01;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_BLEZ  = 6'h06;
    localparam logic [5:0] OP_BGTZ  = 6'h07;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_SLTIU = 6'h0b;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // pcSrc, regDst and memToReg selections
    localparam logic [2:0] PC_SEQ    = 3'b000;
    localparam logic [2:0] PC_BRANCH = 3'b001;
    localparam logic [2:0] PC_JUMP   = 3'b010;
    localparam logic [2:0] PC_REG    = 3'b011;
    localparam logic [2:0] PC_IRQ    = 3'b100;
    localparam logic [2:0] PC_EXC    = 3'b101;
    localparam logic [1:0] DST_RT    = 2'b00;
    localparam logic [1:0] DST_RD    = 2'b01;
    localparam logic [1:0] DST_LINK  = 2'b10;
    localparam logic [1:0] DST_TRAP  = 2'b11;
    localparam logic [1:0] WB_ALU    = 2'b00;
    localparam logic [1:0] WB_MEM    = 2'b01;
    localparam logic [1:0] WB_LINK   = 2'b10;
    localparam logic [1:0] WB_PC     = 2'b11;

    localparam logic [31:0] IRQ_VECTOR = 32'h8000_0004;
    localparam logic [31:0] EXC_VECTOR = 32'h8000_0008;
    localparam logic [4:0]  TRAP_REG   = 5'd26;
    localparam logic [4:0]  LINK_REG   = 5'd31;

    typedef enum logic [5:0] {
        ALU_ADD = 6'b000000, ALU_SUB = 6'b000001,
        ALU_AND = 6'b011000, ALU_OR  = 6'b011110,
        ALU_XOR = 6'b010110, ALU_NOR = 6'b010001,
        ALU_SLL = 6'b100000, ALU_SRL = 6'b100001,
        ALU_SRA = 6'b100011, ALU_LT  = 6'b110101,
        ALU_EQ  = 6'b110011, ALU_NE  = 6'b110001,
        ALU_LEZ = 6'b111101, ALU_GTZ = 6'b111111,
        ALU_LTZ = 6'b111011
    } aluFun_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rInstr_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iInstr_t;

    typedef union packed {
        rInstr_t r;
        iInstr_t i;
    } instr_t; // j target is instr[25:0]

    typedef struct packed {
        logic [2:0] pcSrc;
        logic       sign;
        logic       regWrite;
        logic [1:0] regDst;
        logic       memRead;
        logic       memWrite;
        logic [1:0] memToReg;
        logic       aluSrc1;
        logic       aluSrc2;
        logic       extOp;
        logic       luOp;
        aluFun_t    aluFun;
    } ctrl_t;

endpackage

// File: rtl/issueDispatcher.sv
/* Round-robin dispatch of issue packets, one lane at a time.
   A stalled target lane blocks input even if other lanes are free. */
`timescale 1ns/1ns
module issueDispatcher (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            inValid,
    output logic                            inReady,
    input  pipePkg::issue_t                 inPkt,
    output logic [pipePkg::NUM_LANES-1:0]   laneValid,
    input  logic [pipePkg::NUM_LANES-1:0]   laneReady,
    output pipePkg::issue_t                 lanePkt
);
    import pipePkg::*;

    logic [LANE_W-1:0] ptr;

    assign lanePkt = inPkt;    // shared bus, only one lane sees valid
    assign inReady = laneReady[ptr];

    always_comb begin
        laneValid      = '0;
        laneValid[ptr] = inValid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (inValid && inReady) begin
            ptr <= nextLane(ptr);
        end
    end

endmodule

// File: rtl/pipePkg.sv
/* Issue and result packets of the execute cluster.
   NUM_LANES may be 2, 4 or 8. */
package pipePkg;

    localparam int NUM_LANES = 4;
    localparam int LANE_W    = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    typedef struct packed {
        isaPkg::instr_t instr;
        logic [31:0]    pc;
        logic [31:0]    rsVal;
        logic [31:0]    rtVal;
        logic           irq;
    } issue_t;

    typedef struct packed {
        logic        regWrite;
        logic [4:0]  wbReg;
        logic [31:0] wbVal;     // zero for lw, filled by memory stage
        logic        memRead;
        logic        memWrite;
        logic [31:0] memAddr;
        logic [31:0] storeData;
        logic [31:0] nextPc;
        logic        trap;
    } result_t;

    // round-robin step shared by dispatcher and collector
    function automatic logic [LANE_W-1:0] nextLane(input logic [LANE_W-1:0] idx);
        return (idx == LANE_W'(NUM_LANES - 1)) ? '0 : idx + 1'b1;
    endfunction

endpackage

// File: rtl/resultCollector.sv
/* In-order drain of the lane outputs. The pointer follows the same lane order
   as the dispatcher, so packets leave in the order they entered. */
`timescale 1ns/1ns
module resultCollector (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [pipePkg::NUM_LANES-1:0]   laneValid,
    output logic [pipePkg::NUM_LANES-1:0]   laneReady,
    input  pipePkg::result_t                lanePkt [pipePkg::NUM_LANES],
    output logic                            outValid,
    input  logic                            outReady,
    output pipePkg::result_t                outPkt
);
    import pipePkg::*;

    logic [LANE_W-1:0] ptr;

    assign outValid = laneValid[ptr];
    assign outPkt   = lanePkt[ptr];

    // ready goes back to the oldest lane only
    always_comb begin
        laneReady      = '0;
        laneReady[ptr] = outReady;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (outValid && outReady) begin
            ptr <= nextLane(ptr);
        end
    end

endmodule

// File: sim.f
+incdir+testbench
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/controlDecoder.sv
rtl/aluCore.sv
rtl/execLane.sv
rtl/issueDispatcher.sv
rtl/resultCollector.sv
rtl/execCluster.sv
testbench/execClusterTb.sv

// File: testbench/execModel.svh
/* Expected result packets from MIPS-I subset semantics. Include after importing
   isaPkg and pipePkg. A load's writeback value stays zero for the memory stage. */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic logic [31:0] aluValue(input issue_t p);
    logic [31:0] rs;
    logic [31:0] rt;
    logic [31:0] sImm;
    logic [15:0] imm;
    rs   = p.rsVal;
    rt   = p.rtVal;
    imm  = p.instr.i.imm16;
    sImm = {{16{imm[15]}}, imm};
    case (p.instr.r.opcode)
        OP_RTYPE: begin
            case (p.instr.r.funct)
                FN_SUB, FN_SUBU: return rs - rt;
                FN_AND:  return rs & rt;
                FN_OR:   return rs | rt;
                FN_XOR:  return rs ^ rt;
                FN_NOR:  return ~(rs | rt);
                FN_SLL:  return rt << p.instr.r.shamt;
                FN_SRL:  return rt >> p.instr.r.shamt;
                FN_SRA:  return $signed(rt) >>> p.instr.r.shamt;
                FN_SLT:  return {31'd0, $signed(rs) < $signed(rt)};
                FN_SLTU: return {31'd0, rs < rt};
                default: return rs + rt;    // add, addu, jr, jalr
            endcase
        end
        OP_BEQ:   return {31'd0, rs == rt};
        OP_BNE:   return {31'd0, rs != rt};
        OP_BLEZ:  return {31'd0, $signed(rs) <= 0};
        OP_BGTZ:  return {31'd0, $signed(rs) > 0};
        OP_BLTZ:  return {31'd0, $signed(rs) < 0};
        OP_ANDI:  return rs & {16'd0, imm};
        OP_SLTI:  return {31'd0, $signed(rs) < $signed(sImm)};
        OP_SLTIU: return {31'd0, rs < sImm};    // sign-extended, compared unsigned
        OP_LUI:   return rs + {imm, 16'd0};
        default:  return rs + sImm;    // address and add-immediate forms
    endcase
endfunction

function automatic logic isLegal(input logic [5:0] op);
    case (op)
        OP_RTYPE, OP_BLTZ, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_LUI, OP_LW, OP_SW:
            return 1'b1;
        default:
            return 1'b0;
    endcase
endfunction

function automatic result_t expectedResult(input issue_t p);
    result_t     r;
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [31:0] pc4;
    logic [31:0] alu;
    logic [31:0] jumpPc;
    op     = p.instr.r.opcode;
    fn     = p.instr.r.funct;
    pc4    = p.pc + 32'd4;
    alu    = aluValue(p);
    jumpPc = {pc4[31:28], p.instr[25:0], 2'b00};
    r.memRead   = (op == OP_LW);
    r.memWrite  = (op == OP_SW);
    r.memAddr   = alu;
    r.storeData = p.rtVal;
    r.trap      = p.irq || !isLegal(op);
    r.regWrite  = 1'b1;
    r.wbReg     = p.instr.i.rt;
    r.wbVal     = alu;
    r.nextPc    = pc4;
    if (p.irq) begin
        r.wbReg  = TRAP_REG;
        r.wbVal  = p.pc;    // resume at the interrupted instruction
        r.nextPc = IRQ_VECTOR;
    end else if (r.trap) begin
        r.wbReg  = TRAP_REG;
        r.wbVal  = pc4;
        r.nextPc = EXC_VECTOR;
    end else begin
        case (op)
            OP_RTYPE: begin
                r.wbReg    = p.instr.r.rd;
                r.regWrite = (fn != FN_JR);
                if (fn == FN_JR || fn == FN_JALR) begin
                    r.nextPc = p.rsVal;
                end
                if (fn == FN_JALR) begin
                    r.wbVal = pc4;
                end
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ: begin
                r.regWrite = 1'b0;
                if (alu[0]) begin
                    r.nextPc = pc4 + {{14{p.instr.i.imm16[15]}}, p.instr.i.imm16, 2'b00};
                end
            end
            OP_J: begin
                r.regWrite = 1'b0;
                r.nextPc   = jumpPc;
            end
            OP_JAL: begin
                r.wbReg  = 5'd31;
                r.wbVal  = pc4;
                r.nextPc = jumpPc;
            end
            OP_SW:   r.regWrite = 1'b0;
            OP_LW:   r.wbVal = 32'd0;
            default: r.regWrite = 1'b1;
        endcase
    end
    return r;
endfunction

`endif

// File: testbench/execClusterTb.sv
/* Drives random and directed instruction streams into the execute cluster and
   checks every result in order against the reference model. */
`timescale 1ns/1ns
module execClusterTb;
    import isaPkg::*;
    import pipePkg::*;

    `include "execModel.svh"

    localparam int N_ALU      = 200;
    localparam int N_FLOW     = 120;
    localparam int N_MEM      = 60;
    localparam int N_TRAP     = 60;
    localparam int N_STALL    = 200;
    localparam int TOTAL_PKTS = N_ALU + N_FLOW + N_MEM + N_TRAP + N_STALL + 1;
    localparam int CLK_PERIOD = 100;

    localparam logic [5:0] ALU_FNS [13] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
        FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA, FN_SLT, FN_SLTU};
    localparam logic [5:0] IMM_OPS [6] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
        OP_LUI};
    localparam logic [5:0] FLOW_OPS [7] = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ,
        OP_J, OP_JAL};
    localparam logic [5:0] BAD_OPS [5] = '{6'h0d, 6'h0e, 6'h10, 6'h20, 6'h3f};

    logic        clk;
    logic        rst;
    logic        inValid;
    logic        inReady;
    issue_t      inPkt;
    logic        outValid;
    logic        outReady;
    result_t     outPkt;
    result_t     expQ [$];
    string       nameQ [$];
    string       testName;
    logic        stallMode;
    logic        sawFull;
    int          burstLeft;

    execCluster uut (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inReady(inReady), .inPkt(inPkt),
        .outValid(outValid), .outReady(outReady), .outPkt(outPkt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compareWord(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stopWithFailure($sformatf("Fail %s: %s expected %h actual %h",
                                      name, field, exp, act));
        end
    endtask

    task automatic checkWriteback(input string name, input result_t exp, input result_t act);
        compareWord(name, "regWrite", exp.regWrite, act.regWrite);
        if (exp.regWrite) begin    // reg and value are don't-care otherwise
            compareWord(name, "wbReg", exp.wbReg, act.wbReg);
            compareWord(name, "wbVal", exp.wbVal, act.wbVal);
        end
    endtask

    task automatic checkFlow(input string name, input result_t exp, input result_t act);
        compareWord(name, "nextPc", exp.nextPc, act.nextPc);
        compareWord(name, "trap", exp.trap, act.trap);
        compareWord(name, "memRead", exp.memRead, act.memRead);
        compareWord(name, "memWrite", exp.memWrite, act.memWrite);
        compareWord(name, "memAddr", exp.memAddr, act.memAddr);
        compareWord(name, "storeData", exp.storeData, act.storeData);
    endtask

    function automatic logic [31:0] pickOperand();
        case ($urandom_range(5))
            0: return 32'd0;
            1: return 32'd1;
            2: return 32'h7fff_ffff;
            3: return 32'h8000_0000;
            4: return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic issue_t makePkt(input logic [5:0] op, input logic [5:0] fn);
        issue_t p;
        p.instr          = $urandom;
        p.instr.r.opcode = op;
        if (op == OP_RTYPE) begin
            p.instr.r.funct = fn;
        end
        p.pc    = $urandom & 32'hffff_fffc;
        p.rsVal = pickOperand();
        p.rtVal = ($urandom_range(3) == 0) ? p.rsVal : pickOperand();    // equal for beq
        p.irq   = 1'b0;
        return p;
    endfunction

    function automatic issue_t randomMix();
        case ($urandom_range(3))
            0: return makePkt(OP_RTYPE, ALU_FNS[$urandom_range(12)]);
            1: return makePkt(IMM_OPS[$urandom_range(5)], 6'd0);
            2: return makePkt(FLOW_OPS[$urandom_range(6)], 6'd0);
            default: return makePkt($urandom_range(1) ? OP_LW : OP_SW, 6'd0);
        endcase
    endfunction

    // returns on the edge where the packet was taken
    task automatic sendPacket(input string name, input issue_t p);
        inValid  <= 1'b1;
        inPkt    <= p;
        testName <= name;
        do begin
            @(posedge clk);
        end while (!inReady);
    endtask

    task automatic resetTest();
        @(posedge clk);
        if (outValid !== 1'b0) begin
            stopWithFailure("outValid was high on the first cycle after reset");
        end
        if (inReady !== 1'b1) begin
            stopWithFailure("inReady was low on the first cycle after reset");
        end
        sendPacket("single packet", randomMix());
        inValid <= 1'b0;
        @(posedge clk);
        if (outValid !== 1'b1) begin
            stopWithFailure("single packet did not appear one cycle after its transfer");
        end
    endtask

    task automatic aluTests();
        for (int k = 0; k < N_ALU; k++) begin
            if (k % 2 == 0) begin
                sendPacket("alu rtype", makePkt(OP_RTYPE, ALU_FNS[$urandom_range(12)]));
            end else begin
                sendPacket("alu immediate", makePkt(IMM_OPS[$urandom_range(5)], 6'd0));
            end
        end
    endtask

    task automatic flowTests();
        int sel;
        for (int k = 0; k < N_FLOW; k++) begin
            sel = $urandom_range(8);
            if (sel < 7) begin
                sendPacket("branch or jump", makePkt(FLOW_OPS[sel], 6'd0));
            end else begin
                sendPacket("jr or jalr", makePkt(OP_RTYPE, (sel == 7) ? FN_JR : FN_JALR));
            end
        end
    endtask

    task automatic memoryTests();
        for (int k = 0; k < N_MEM; k++) begin
            sendPacket("load store", makePkt((k % 2 == 0) ? OP_LW : OP_SW, 6'd0));
        end
    endtask

    task automatic trapTests();
        issue_t p;
        for (int k = 0; k < N_TRAP; k++) begin
            if (k % 2 == 0) begin
                p     = makePkt(6'($urandom), 6'($urandom));    // any opcode
                p.irq = 1'b1;
            end else begin
                p = makePkt(BAD_OPS[$urandom_range(4)], 6'd0);
            end
            sendPacket(p.irq ? "irq trap" : "illegal opcode", p);
        end
    endtask

    // outReady stalls longer than the lane count
    always @(posedge clk) begin
        if (!stallMode) begin
            outReady <= 1'b1;
        end else if (burstLeft > 0) begin
            burstLeft <= burstLeft - 1;
        end else begin
            outReady  <= !outReady;
            burstLeft <= outReady ? $urandom_range(NUM_LANES + 4, NUM_LANES + 1)
                                  : $urandom_range(3, 1);
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (expQ.size() == NUM_LANES && !outReady) begin
                if (inReady) begin
                    stopWithFailure("inReady stayed high with every lane full");
                end
                sawFull <= 1'b1;
            end
            if (inValid && inReady) begin
                expQ.push_back(expectedResult(inPkt));
                nameQ.push_back(testName);
            end
            if (outValid && outReady) begin
                if (expQ.size() == 0) begin
                    stopWithFailure("a result left the cluster with no packet outstanding");
                end else begin
                    checkWriteback(nameQ[0], expQ[0], outPkt);
                    checkFlow(nameQ[0], expQ[0], outPkt);
                    void'(expQ.pop_front());
                    void'(nameQ.pop_front());
                end
            end
        end
    end

    initial begin
        #((TOTAL_PKTS * 20 + 200) * CLK_PERIOD);
        stopWithFailure("timeout while waiting for the cluster to deliver all results");
    end

    initial begin
        void'($urandom(95407));
        clk       = 1'b0;
        rst       = 1'b1;
        inValid   = 1'b0;
        inPkt     = '0;
        outReady  = 1'b1;
        stallMode = 1'b0;
        sawFull   = 1'b0;
        burstLeft = 0;
        testName  = "reset";
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        resetTest();
        aluTests();
        flowTests();
        memoryTests();
        trapTests();
        stallMode <= 1'b1;
        for (int k = 0; k < N_STALL; k++) begin
            sendPacket("back-pressure", randomMix());
        end
        inValid   <= 1'b0;
        stallMode <= 1'b0;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (!sawFull) begin
            stopWithFailure("inReady never fell with every lane full");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule
